/* verilog/accel_ctrl_defines.svh */
`ifndef ACCEL_CTRL_DEFINES_SVH
`define ACCEL_CTRL_DEFINES_SVH

// ---------------------------------------------------------------------------
// Bus geometry
// ---------------------------------------------------------------------------
`define AXI_ADDR_W          6
`define AXI_DATA_W          32
// Word index starts above the byte offset
`define REG_ADDR_LSB        2
`define REG_INDEX_W         4

// ---------------------------------------------------------------------------
// Register map, word indices
// ---------------------------------------------------------------------------
`define REG_CTRL            4'd0
`define REG_STATUS          4'd1
`define REG_MEM0_ADDR       4'd2
`define REG_MEM0_DATA       4'd3
`define REG_MEM1_ADDR       4'd4
`define REG_MEM1_DATA       4'd5

// Instruction memory, 1024 words
`define MEM0_ADDR_W         10
// MRAM, 65536 words
`define MEM1_ADDR_W         16

// Control and status bit positions
`define RUN_BIT             31
`define STATUS_IDLE_BIT     0
`define STATUS_RUNNING_BIT  1
`define STATUS_DONE_BIT     2

`endif

/* verilog/accel_ctrl_pkg.sv */
`include "accel_ctrl_defines.svh"

package accel_ctrl_pkg;

	// Byte address as seen on the AXI4-Lite channels
	typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;

	// Bus word, also the width of every register
	typedef logic [`AXI_DATA_W-1:0] axi_data_t;

	// One strobe per byte lane
	typedef logic [`AXI_DATA_W/8-1:0] axi_strb_t;

	// Response code on B and R channels
	typedef logic [1:0] axi_resp_t;

	// Word index into the register map
	typedef logic [`REG_INDEX_W-1:0] reg_index_t;

	// Job count field, everything below the run bit
	typedef logic [`RUN_BIT-1:0] job_count_t;

	// Only response this slave ever returns
	localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

/* verilog/axi_lite_slave.sv */
`timescale 1ns/100ps
`include "accel_ctrl_defines.svh"

module axi_lite_slave (
	input  logic                    clk,
	input  logic                    reset_n,
	// Write address and data channels
	input  accel_ctrl_pkg::axi_addr_t i_awaddr,
	input  logic                    i_awvalid,
	output logic                    o_awready,
	input  accel_ctrl_pkg::axi_data_t i_wdata,
	input  accel_ctrl_pkg::axi_strb_t i_wstrb,
	input  logic                    i_wvalid,
	output logic                    o_wready,
	// Write response channel
	output accel_ctrl_pkg::axi_resp_t o_bresp,
	output logic                    o_bvalid,
	input  logic                    i_bready,
	// Read address and data channels
	input  accel_ctrl_pkg::axi_addr_t i_araddr,
	input  logic                    i_arvalid,
	output logic                    o_arready,
	output accel_ctrl_pkg::axi_data_t o_rdata,
	output accel_ctrl_pkg::axi_resp_t o_rresp,
	output logic                    o_rvalid,
	input  logic                    i_rready,
	// Register access side
	output logic                    o_wr_en,
	output accel_ctrl_pkg::reg_index_t o_wr_index,
	output accel_ctrl_pkg::axi_data_t o_wr_data,
	output accel_ctrl_pkg::axi_strb_t o_wr_strb,
	output logic                    o_rd_en,
	output accel_ctrl_pkg::reg_index_t o_rd_index,
	input  accel_ctrl_pkg::axi_data_t i_rd_data
);
	import accel_ctrl_pkg::*;

	// Read engine: accept, wait for memory, hold valid
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_WAIT,
		RD_VALID
	} rd_state_t;

	logic       wr_accept;
	logic       wr_go;
	logic       bvalid_q;
	reg_index_t wr_index_q;
	rd_state_t  rd_state;
	reg_index_t rd_index_q;
	axi_data_t  rdata_q;

	// ---------------------------------------------------------------------------
	// Write channel
	// ---------------------------------------------------------------------------
	// Both halves present, nothing in flight, no response pending
	assign wr_accept = i_awvalid & i_wvalid & ~wr_go & ~bvalid_q;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_go    <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			wr_go <= wr_accept;
			// Response follows the ready cycle, held until bready
			if (wr_go) begin
				bvalid_q <= 1'b1;
			end else if (i_bready) begin
				bvalid_q <= 1'b0;
			end
		end
	end

	// Word index of the accepted write
	always_ff @(posedge clk) begin
		if (wr_accept) begin
			wr_index_q <= i_awaddr[`REG_ADDR_LSB +: `REG_INDEX_W];
		end
	end

	// AW and W complete together in one cycle
	assign o_awready  = wr_go;
	assign o_wready   = wr_go;
	assign o_bvalid   = bvalid_q;
	assign o_bresp    = RESP_OKAY;

	// Host still drives wdata and wstrb during the handshake cycle
	assign o_wr_en    = wr_go;
	assign o_wr_index = wr_index_q;
	assign o_wr_data  = i_wdata;
	assign o_wr_strb  = i_wstrb;

	// ---------------------------------------------------------------------------
	// Read channel
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					if (i_arvalid) begin
						rd_state <= RD_ADDR;
					end
				end
				// Memory sees its strobe here
				RD_ADDR:  rd_state <= RD_WAIT;
				// Memory output settles, data captured at the end
				RD_WAIT:  rd_state <= RD_VALID;
				RD_VALID: begin
					if (i_rready) begin
						rd_state <= RD_IDLE;
					end
				end
				default:  rd_state <= RD_IDLE;
			endcase
		end
	end

	// Index and returned word
	always_ff @(posedge clk) begin
		if (rd_state == RD_IDLE && i_arvalid) begin
			rd_index_q <= i_araddr[`REG_ADDR_LSB +: `REG_INDEX_W];
		end
		if (rd_state == RD_WAIT) begin
			rdata_q <= i_rd_data;
		end
	end

	assign o_arready  = (rd_state == RD_ADDR);
	assign o_rd_en    = (rd_state == RD_ADDR);
	assign o_rd_index = rd_index_q;
	assign o_rvalid   = (rd_state == RD_VALID);
	assign o_rdata    = rdata_q;
	assign o_rresp    = RESP_OKAY;

	// ---------------------------------------------------------------------------
	// Protocol checks
	// ---------------------------------------------------------------------------
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!reset_n)
		o_bvalid && !i_bready |=> o_bvalid);

	a_rvalid_hold: assert property (@(posedge clk) disable iff (!reset_n)
		o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata));

	// Register side never sees a write with a response outstanding
	a_no_wr_in_resp: assert property (@(posedge clk) disable iff (!reset_n)
		!(o_wr_en && o_bvalid));

endmodule

/* verilog/reg_decoder.sv */
`timescale 1ns/100ps
`include "accel_ctrl_defines.svh"

module reg_decoder (
	// Access strobes from the bus slave
	input  logic                       i_wr_en,
	input  accel_ctrl_pkg::reg_index_t i_wr_index,
	input  logic                       i_rd_en,
	input  accel_ctrl_pkg::reg_index_t i_rd_index,
	// Read sources
	input  accel_ctrl_pkg::axi_data_t  i_ctrl,
	input  accel_ctrl_pkg::axi_data_t  i_status,
	input  accel_ctrl_pkg::axi_data_t  i_mem0_addr_reg,
	input  accel_ctrl_pkg::axi_data_t  i_mem0_q,
	input  accel_ctrl_pkg::axi_data_t  i_mem1_addr_reg,
	input  accel_ctrl_pkg::axi_data_t  i_mem1_q,
	// Target pulses
	output logic                       o_ctrl_wr,
	output logic                       o_mem0_addr_wr,
	output logic                       o_mem0_access,
	output logic                       o_mem0_write,
	output logic                       o_mem1_addr_wr,
	output logic                       o_mem1_access,
	output logic                       o_mem1_write,
	output accel_ctrl_pkg::axi_data_t  o_rd_data
);

	logic wr_mem0_data;
	logic rd_mem0_data;
	logic wr_mem1_data;
	logic rd_mem1_data;

	// Status is read only, so no write pulse exists for it
	assign o_ctrl_wr      = i_wr_en && (i_wr_index == `REG_CTRL);
	assign o_mem0_addr_wr = i_wr_en && (i_wr_index == `REG_MEM0_ADDR);
	assign o_mem1_addr_wr = i_wr_en && (i_wr_index == `REG_MEM1_ADDR);

	// Data window hits, either direction
	assign wr_mem0_data   = i_wr_en && (i_wr_index == `REG_MEM0_DATA);
	assign rd_mem0_data   = i_rd_en && (i_rd_index == `REG_MEM0_DATA);
	assign wr_mem1_data   = i_wr_en && (i_wr_index == `REG_MEM1_DATA);
	assign rd_mem1_data   = i_rd_en && (i_rd_index == `REG_MEM1_DATA);

	assign o_mem0_access  = wr_mem0_data | rd_mem0_data;
	assign o_mem0_write   = wr_mem0_data;
	assign o_mem1_access  = wr_mem1_data | rd_mem1_data;
	assign o_mem1_write   = wr_mem1_data;

	// ---------------------------------------------------------------------------
	// Read mux
	// ---------------------------------------------------------------------------
	// Data windows return the memory output of the previous cycle's access
	always_comb begin
		case (i_rd_index)
			`REG_CTRL:      o_rd_data = i_ctrl;
			`REG_STATUS:    o_rd_data = i_status;
			`REG_MEM0_ADDR: o_rd_data = i_mem0_addr_reg;
			`REG_MEM0_DATA: o_rd_data = i_mem0_q;
			`REG_MEM1_ADDR: o_rd_data = i_mem1_addr_reg;
			`REG_MEM1_DATA: o_rd_data = i_mem1_q;
			// Unused indices 6 to 15
			default:        o_rd_data = '0;
		endcase
	end

endmodule

/* verilog/ctrl_status_regs.sv */
`timescale 1ns/100ps
`include "accel_ctrl_defines.svh"

module ctrl_status_regs (
	input  logic                       clk,
	input  logic                       reset_n,
	// Control write from the decoder
	input  logic                       i_ctrl_wr,
	input  accel_ctrl_pkg::axi_data_t  i_wr_data,
	input  accel_ctrl_pkg::axi_strb_t  i_wr_strb,
	// Accelerator state
	input  logic                       i_idle,
	input  logic                       i_running,
	input  logic                       i_done,
	// Register views and accelerator controls
	output accel_ctrl_pkg::axi_data_t  o_ctrl,
	output accel_ctrl_pkg::axi_data_t  o_status,
	output logic                       o_run,
	output accel_ctrl_pkg::job_count_t o_num_cnt
);

	logic run_q;
	logic idle_q;
	logic running_q;
	logic done_q;

	// ---------------------------------------------------------------------------
	// Control register
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			o_ctrl <= '0;
		end else if (i_ctrl_wr) begin
			// Byte lanes follow the write strobes
			for (int b = 0; b < $bits(i_wr_strb); b++) begin
				if (i_wr_strb[b]) begin
					o_ctrl[b*8 +: 8] <= i_wr_data[b*8 +: 8];
				end
			end
		end
	end

	// Previous run bit for edge detection
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			run_q <= 1'b0;
		end else begin
			run_q <= o_ctrl[`RUN_BIT];
		end
	end

	// One tick when run goes 0 to 1, rewriting a 1 does nothing
	assign o_run     = o_ctrl[`RUN_BIT] & ~run_q;
	assign o_num_cnt = o_ctrl[`RUN_BIT-1:0];

	// ---------------------------------------------------------------------------
	// Status
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			idle_q    <= 1'b0;
			running_q <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			idle_q    <= i_idle;
			running_q <= i_running;
			// Sticky done, set has priority over the clearing run pulse
			if (i_done) begin
				done_q <= 1'b1;
			end else if (o_run) begin
				done_q <= 1'b0;
			end
		end
	end

	always_comb begin
		o_status                      = '0;
		o_status[`STATUS_IDLE_BIT]    = idle_q;
		o_status[`STATUS_RUNNING_BIT] = running_q;
		o_status[`STATUS_DONE_BIT]    = done_q;
	end

	a_run_single: assert property (@(posedge clk) disable iff (!reset_n)
		o_run |=> !o_run);

endmodule

/* verilog/mem_port_channel.sv */
`timescale 1ns/100ps

module mem_port_channel #(
	parameter int ADDR_W = 10
) (
	input  logic                      clk,
	input  logic                      reset_n,
	// Pulses from the decoder
	input  logic                      i_addr_wr,
	input  logic                      i_access,
	input  logic                      i_write,
	input  accel_ctrl_pkg::axi_data_t i_wr_data,
	// Readback of the address register
	output accel_ctrl_pkg::axi_data_t o_addr_reg,
	// External synchronous memory
	output logic [ADDR_W-1:0]         o_mem_addr,
	output logic                      o_mem_ce,
	output logic                      o_mem_we,
	output accel_ctrl_pkg::axi_data_t o_mem_d
);

	logic [ADDR_W-1:0] addr_cnt;

	// Address register keeps the full word, counter only the memory width
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			o_addr_reg <= '0;
			addr_cnt   <= '0;
		end else if (i_addr_wr) begin
			o_addr_reg <= i_wr_data;
			addr_cnt   <= i_wr_data[ADDR_W-1:0];
		end else if (i_access) begin
			// Post increment after each window access
			addr_cnt   <= addr_cnt + 1'b1;
		end
	end

	// Strobes go straight out in the access cycle
	assign o_mem_addr = addr_cnt;
	assign o_mem_ce   = i_access;
	assign o_mem_we   = i_write;
	assign o_mem_d    = i_wr_data;

	a_we_needs_ce: assert property (@(posedge clk) disable iff (!reset_n)
		o_mem_we |-> o_mem_ce);

endmodule

/* verilog/accel_ctrl_top.sv */
`timescale 1ns/100ps
`include "accel_ctrl_defines.svh"

module accel_ctrl_top (
	input  logic                       clk,
	input  logic                       reset_n,
	// AXI4-Lite slave
	input  accel_ctrl_pkg::axi_addr_t  i_awaddr,
	input  logic                       i_awvalid,
	output logic                       o_awready,
	input  accel_ctrl_pkg::axi_data_t  i_wdata,
	input  accel_ctrl_pkg::axi_strb_t  i_wstrb,
	input  logic                       i_wvalid,
	output logic                       o_wready,
	output accel_ctrl_pkg::axi_resp_t  o_bresp,
	output logic                       o_bvalid,
	input  logic                       i_bready,
	input  accel_ctrl_pkg::axi_addr_t  i_araddr,
	input  logic                       i_arvalid,
	output logic                       o_arready,
	output accel_ctrl_pkg::axi_data_t  o_rdata,
	output accel_ctrl_pkg::axi_resp_t  o_rresp,
	output logic                       o_rvalid,
	input  logic                       i_rready,
	// Accelerator core
	input  logic                       i_idle,
	input  logic                       i_running,
	input  logic                       i_done,
	output logic                       o_run,
	output accel_ctrl_pkg::job_count_t o_num_cnt,
	// Instruction memory
	output logic [`MEM0_ADDR_W-1:0]    o_mem0_addr,
	output logic                       o_mem0_ce,
	output logic                       o_mem0_we,
	output accel_ctrl_pkg::axi_data_t  o_mem0_d,
	input  accel_ctrl_pkg::axi_data_t  i_mem0_q,
	// MRAM
	output logic [`MEM1_ADDR_W-1:0]    o_mem1_addr,
	output logic                       o_mem1_ce,
	output logic                       o_mem1_we,
	output accel_ctrl_pkg::axi_data_t  o_mem1_d,
	input  accel_ctrl_pkg::axi_data_t  i_mem1_q
);
	import accel_ctrl_pkg::*;

	// Slave to decoder
	logic       wr_en;
	reg_index_t wr_index;
	axi_data_t  wr_data;
	axi_strb_t  wr_strb;
	logic       rd_en;
	reg_index_t rd_index;
	axi_data_t  rd_data;

	// Decoder to targets
	logic       ctrl_wr;
	logic       mem0_addr_wr;
	logic       mem0_access;
	logic       mem0_write;
	logic       mem1_addr_wr;
	logic       mem1_access;
	logic       mem1_write;

	// Register views back to the read mux
	axi_data_t  ctrl;
	axi_data_t  status;
	axi_data_t  mem0_addr_reg;
	axi_data_t  mem1_addr_reg;

	axi_lite_slave u_slave (
		.clk        (clk),
		.reset_n    (reset_n),
		.i_awaddr   (i_awaddr),
		.i_awvalid  (i_awvalid),
		.o_awready  (o_awready),
		.i_wdata    (i_wdata),
		.i_wstrb    (i_wstrb),
		.i_wvalid   (i_wvalid),
		.o_wready   (o_wready),
		.o_bresp    (o_bresp),
		.o_bvalid   (o_bvalid),
		.i_bready   (i_bready),
		.i_araddr   (i_araddr),
		.i_arvalid  (i_arvalid),
		.o_arready  (o_arready),
		.o_rdata    (o_rdata),
		.o_rresp    (o_rresp),
		.o_rvalid   (o_rvalid),
		.i_rready   (i_rready),
		.o_wr_en    (wr_en),
		.o_wr_index (wr_index),
		.o_wr_data  (wr_data),
		.o_wr_strb  (wr_strb),
		.o_rd_en    (rd_en),
		.o_rd_index (rd_index),
		.i_rd_data  (rd_data)
	);

	reg_decoder u_decoder (
		.i_wr_en         (wr_en),
		.i_wr_index      (wr_index),
		.i_rd_en         (rd_en),
		.i_rd_index      (rd_index),
		.i_ctrl          (ctrl),
		.i_status        (status),
		.i_mem0_addr_reg (mem0_addr_reg),
		.i_mem0_q        (i_mem0_q),
		.i_mem1_addr_reg (mem1_addr_reg),
		.i_mem1_q        (i_mem1_q),
		.o_ctrl_wr       (ctrl_wr),
		.o_mem0_addr_wr  (mem0_addr_wr),
		.o_mem0_access   (mem0_access),
		.o_mem0_write    (mem0_write),
		.o_mem1_addr_wr  (mem1_addr_wr),
		.o_mem1_access   (mem1_access),
		.o_mem1_write    (mem1_write),
		.o_rd_data       (rd_data)
	);

	ctrl_status_regs u_ctrl (
		.clk       (clk),
		.reset_n   (reset_n),
		.i_ctrl_wr (ctrl_wr),
		.i_wr_data (wr_data),
		.i_wr_strb (wr_strb),
		.i_idle    (i_idle),
		.i_running (i_running),
		.i_done    (i_done),
		.o_ctrl    (ctrl),
		.o_status  (status),
		.o_run     (o_run),
		.o_num_cnt (o_num_cnt)
	);

	// ---------------------------------------------------------------------------
	// Memory ports, same channel at two address widths
	// ---------------------------------------------------------------------------
	mem_port_channel #(
		.ADDR_W (`MEM0_ADDR_W)
	) u_mem0_chan (
		.clk        (clk),
		.reset_n    (reset_n),
		.i_addr_wr  (mem0_addr_wr),
		.i_access   (mem0_access),
		.i_write    (mem0_write),
		.i_wr_data  (wr_data),
		.o_addr_reg (mem0_addr_reg),
		.o_mem_addr (o_mem0_addr),
		.o_mem_ce   (o_mem0_ce),
		.o_mem_we   (o_mem0_we),
		.o_mem_d    (o_mem0_d)
	);

	mem_port_channel #(
		.ADDR_W (`MEM1_ADDR_W)
	) u_mem1_chan (
		.clk        (clk),
		.reset_n    (reset_n),
		.i_addr_wr  (mem1_addr_wr),
		.i_access   (mem1_access),
		.i_write    (mem1_write),
		.i_wr_data  (wr_data),
		.o_addr_reg (mem1_addr_reg),
		.o_mem_addr (o_mem1_addr),
		.o_mem_ce   (o_mem1_ce),
		.o_mem_we   (o_mem1_we),
		.o_mem_d    (o_mem1_d)
	);

endmodule

/* verification/accel_ctrl_tb_tasks.svh */
`ifndef ACCEL_CTRL_TB_TASKS_SVH
`define ACCEL_CTRL_TB_TASKS_SVH

// ---------------------------------------------------------------------------
// Failure, table and random helpers
// ---------------------------------------------------------------------------
task automatic fail_now(input string msg);
	$display("%s", msg);
	$display("TEST RESULT: FAIL");
	$fatal(1, "Stopped at the first error");
endtask

task automatic add_row(input op_kind_t kind, input reg_index_t idx, input axi_data_t data,
	input axi_strb_t strb, input axi_data_t exp);
	stim_row_t row;
	row.kind = kind;
	row.idx  = idx;
	row.data = data;
	row.strb = strb;
	row.exp  = exp;
	stim_q.push_back(row);
endtask

// Galois LFSR, one step per bit taken
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] take_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int b = 0; b < n; b++) begin
		lfsr_state = lfsr_step(lfsr_state);
		v = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

// Byte lane write rule of the control register
function automatic axi_data_t merge_lanes(input axi_data_t old, input axi_data_t data,
	input axi_strb_t strb);
	axi_data_t v;
	v = old;
	for (int b = 0; b < 4; b++) begin
		if (strb[b]) v[b*8 +: 8] = data[b*8 +: 8];
	end
	return v;
endfunction

// ---------------------------------------------------------------------------
// Compare tasks
// ---------------------------------------------------------------------------
task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
	if (exp !== act) fail_now($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
	if (exp !== act) fail_now($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_count(input string name, input job_count_t exp, input job_count_t act);
	if (exp !== act) fail_now($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
endtask

// ---------------------------------------------------------------------------
// Bus tasks, entered and left on a falling edge
// ---------------------------------------------------------------------------
task automatic bus_write(input reg_index_t idx, input axi_data_t data, input axi_strb_t strb);
	int hold;
	awaddr  = {idx, 2'b00};
	wdata   = data;
	wstrb   = strb;
	awvalid = 1'b1;
	wvalid  = 1'b1;
	do @(negedge clk); while (!awready);
	// AW and W handshake in the same cycle
	if (!wready) begin
		fail_now("Write data channel was not ready in the address handshake cycle");
	end
	// Data stays on the bus through the ready cycle
	awvalid = 1'b0;
	wvalid  = 1'b0;
	while (!bvalid) @(negedge clk);
	check_resp("write response", RESP_OKAY, bresp);
	hold = int'(take_bits(2));
	repeat (hold) @(negedge clk);
	bready = 1'b1;
	@(negedge clk);
	bready = 1'b0;
endtask

task automatic bus_read(input reg_index_t idx, output axi_data_t data);
	int hold;
	araddr  = {idx, 2'b00};
	arvalid = 1'b1;
	do @(negedge clk); while (!arready);
	arvalid = 1'b0;
	while (!rvalid) @(negedge clk);
	hold = int'(take_bits(2));
	repeat (hold) @(negedge clk);
	data = rdata;
	check_resp("read response", RESP_OKAY, rresp);
	rready = 1'b1;
	@(negedge clk);
	rready = 1'b0;
endtask

// Bit 0 idle, bit 1 running, bit 2 a done pulse
task automatic pulse_inputs(input axi_data_t v);
	idle    = v[0];
	running = v[1];
	done    = v[2];
	@(negedge clk);
	done = 1'b0;
	repeat (2) @(negedge clk);
endtask

`endif

/* verification/accel_ctrl_tb.sv */
`timescale 1ns/100ps
`include "accel_ctrl_defines.svh"

module accel_ctrl_tb;
	import accel_ctrl_pkg::*;

	// Kinds of table rows
	typedef enum logic [1:0] {
		OP_WRITE,
		OP_READ,
		OP_PULSE
	} op_kind_t;

	// One bus operation and what it must return
	typedef struct {
		op_kind_t   kind;
		reg_index_t idx;
		axi_data_t  data;
		axi_strb_t  strb;
		axi_data_t  exp;
	} stim_row_t;

	logic       clk;
	logic       reset_n;
	axi_addr_t  awaddr;
	logic       awvalid;
	logic       awready;
	axi_data_t  wdata;
	axi_strb_t  wstrb;
	logic       wvalid;
	logic       wready;
	axi_resp_t  bresp;
	logic       bvalid;
	logic       bready;
	axi_addr_t  araddr;
	logic       arvalid;
	logic       arready;
	axi_data_t  rdata;
	axi_resp_t  rresp;
	logic       rvalid;
	logic       rready;
	logic       idle;
	logic       running;
	logic       done;
	logic       run;
	job_count_t num_cnt;
	logic [`MEM0_ADDR_W-1:0] mem0_addr;
	logic       mem0_ce;
	logic       mem0_we;
	axi_data_t  mem0_d;
	axi_data_t  mem0_q;
	logic [`MEM1_ADDR_W-1:0] mem1_addr;
	logic       mem1_ce;
	logic       mem1_we;
	axi_data_t  mem1_d;
	axi_data_t  mem1_q;

	// Memory models and their shadow copies
	axi_data_t  mem0 [0:(1<<`MEM0_ADDR_W)-1];
	axi_data_t  mem1 [0:(1<<`MEM1_ADDR_W)-1];
	axi_data_t  shadow0 [0:(1<<`MEM0_ADDR_W)-1];
	axi_data_t  shadow1 [0:(1<<`MEM1_ADDR_W)-1];

	stim_row_t  stim_q [$];
	logic [31:0] lfsr_state;
	int         cycles;
	int         cycle_limit;
	int         run_count;

	accel_ctrl_top uut (
		.clk(clk), .reset_n(reset_n),
		.i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready),
		.i_wdata(wdata), .i_wstrb(wstrb), .i_wvalid(wvalid), .o_wready(wready),
		.o_bresp(bresp), .o_bvalid(bvalid), .i_bready(bready),
		.i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready),
		.o_rdata(rdata), .o_rresp(rresp), .o_rvalid(rvalid), .i_rready(rready),
		.i_idle(idle), .i_running(running), .i_done(done),
		.o_run(run), .o_num_cnt(num_cnt),
		.o_mem0_addr(mem0_addr), .o_mem0_ce(mem0_ce), .o_mem0_we(mem0_we),
		.o_mem0_d(mem0_d), .i_mem0_q(mem0_q),
		.o_mem1_addr(mem1_addr), .o_mem1_ce(mem1_ce), .o_mem1_we(mem1_we),
		.o_mem1_d(mem1_d), .i_mem1_q(mem1_q)
	);

	`include "accel_ctrl_tb_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Synchronous memories, data out one cycle after a read strobe
	always @(posedge clk) begin
		if (mem0_ce && mem0_we) mem0[mem0_addr] <= mem0_d;
		else if (mem0_ce) mem0_q <= mem0[mem0_addr];
		if (mem1_ce && mem1_we) mem1[mem1_addr] <= mem1_d;
		else if (mem1_ce) mem1_q <= mem1[mem1_addr];
	end

	// Run pulse is a full cycle long, so one falling edge sees it
	always @(negedge clk) begin
		if (reset_n && run) run_count++;
	end

	// Hang guard
	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			fail_now("Run did not finish within the cycle limit");
		end
	end

	// ---------------------------------------------------------------------------
	// Stimulus table
	// ---------------------------------------------------------------------------
	task automatic build_table();
		add_row(OP_READ,  `REG_CTRL,   32'h0, 4'h0, 32'h0000_0000);
		add_row(OP_READ,  `REG_STATUS, 32'h0, 4'h0, 32'h0000_0001);
		// Accelerator starts running
		add_row(OP_PULSE, 4'd0,        32'h2, 4'h0, 32'h0);
		add_row(OP_READ,  `REG_STATUS, 32'h0, 4'h0, 32'h0000_0002);
		// Partial strobes, lanes 0 and 2 only
		add_row(OP_WRITE, `REG_CTRL,   32'h1234_5678, 4'b0101, 32'h0);
		add_row(OP_READ,  `REG_CTRL,   32'h0, 4'h0, 32'h0034_0078);
		add_row(OP_WRITE, `REG_CTRL,   32'hab00_0000, 4'b1000, 32'h0);
		add_row(OP_READ,  `REG_CTRL,   32'h0, 4'h0, 32'hab34_0078);
		// Run bit already set, no new pulse
		add_row(OP_WRITE, `REG_CTRL,   32'h8000_0011, 4'b1001, 32'h0);
		add_row(OP_PULSE, 4'd0,        32'h6, 4'h0, 32'h0);
		add_row(OP_READ,  `REG_STATUS, 32'h0, 4'h0, 32'h0000_0006);
		// Done stays sticky
		add_row(OP_PULSE, 4'd0,        32'h2, 4'h0, 32'h0);
		add_row(OP_READ,  `REG_STATUS, 32'h0, 4'h0, 32'h0000_0006);
		add_row(OP_WRITE, `REG_CTRL,   32'h0000_0000, 4'b1000, 32'h0);
		add_row(OP_WRITE, `REG_CTRL,   32'h8000_0000, 4'b1000, 32'h0);
		add_row(OP_READ,  `REG_STATUS, 32'h0, 4'h0, 32'h0000_0002);
		// Instruction memory burst, wraps past the top word
		add_row(OP_WRITE, `REG_MEM0_ADDR, 32'h0000_03fc, 4'hf, 32'h0);
		for (int i = 0; i < 6; i++) begin
			add_row(OP_WRITE, `REG_MEM0_DATA, 32'h0, 4'hf, 32'h0);
		end
		add_row(OP_READ,  `REG_MEM0_ADDR, 32'h0, 4'h0, 32'h0000_03fc);
		// MRAM read burst
		add_row(OP_WRITE, `REG_MEM1_ADDR, 32'h0000_1230, 4'hf, 32'h0);
		for (int i = 0; i < 5; i++) begin
			add_row(OP_READ, `REG_MEM1_DATA, 32'h0, 4'h0, 32'h0);
		end
		add_row(OP_READ,  `REG_MEM1_ADDR, 32'h0, 4'h0, 32'h0000_1230);
		// Unused indices and the read-only status
		add_row(OP_WRITE, 4'd6,        32'hffff_ffff, 4'hf, 32'h0);
		add_row(OP_READ,  4'd6,        32'h0, 4'h0, 32'h0);
		add_row(OP_WRITE, 4'd15,       32'hffff_ffff, 4'hf, 32'h0);
		add_row(OP_READ,  4'd15,       32'h0, 4'h0, 32'h0);
		add_row(OP_READ,  4'd9,        32'h0, 4'h0, 32'h0);
		add_row(OP_WRITE, `REG_STATUS, 32'hffff_ffff, 4'hf, 32'h0);
		add_row(OP_READ,  `REG_STATUS, 32'h0, 4'h0, 32'h0000_0002);
		add_row(OP_READ,  `REG_CTRL,   32'h0, 4'h0, 32'h8034_0011);
	endtask

	initial begin
		axi_data_t  ctrl_shadow;
		axi_data_t  data;
		axi_data_t  exp;
		logic [`MEM0_ADDR_W-1:0] cnt0;
		logic [`MEM1_ADDR_W-1:0] cnt1;
		int         exp_runs;
		string      name;

		reset_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		idle = 1'b1;
		running = 1'b0;
		done = 1'b0;
		mem0_q = '0;
		mem1_q = '0;
		lfsr_state = 32'h1e11_c11c;
		cycles = 0;
		run_count = 0;
		ctrl_shadow = '0;
		cnt0 = '0;
		cnt1 = '0;
		exp_runs = 0;
		// Fill patterns built from every address bit
		for (int a = 0; a < (1 << `MEM0_ADDR_W); a++) begin
			mem0[a] = {6'h2a, a[9:0], ~a[9:0], 6'h15};
			shadow0[a] = mem0[a];
		end
		for (int a = 0; a < (1 << `MEM1_ADDR_W); a++) begin
			mem1[a] = {~a[15:0], a[15:0]} ^ 32'h5a5a_0f0f;
			shadow1[a] = mem1[a];
		end
		build_table();
		cycle_limit = stim_q.size() * 20 + 100;

		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		@(negedge clk);

		foreach (stim_q[i]) begin
			name = $sformatf("row %0d idx %0d", i, stim_q[i].idx);
			case (stim_q[i].kind)
				OP_WRITE: begin
					data = stim_q[i].data;
					if (stim_q[i].idx == `REG_MEM0_DATA || stim_q[i].idx == `REG_MEM1_DATA)
						data = take_bits(32);
					bus_write(stim_q[i].idx, data, stim_q[i].strb);
					if (stim_q[i].idx == `REG_CTRL) begin
						// Rising run bit means one pulse
						if (!ctrl_shadow[`RUN_BIT] && data[`RUN_BIT] && stim_q[i].strb[3])
							exp_runs++;
						ctrl_shadow = merge_lanes(ctrl_shadow, data, stim_q[i].strb);
						check_count(name, ctrl_shadow[`RUN_BIT-1:0], num_cnt);
						check_data({name, " run pulses"}, axi_data_t'(exp_runs),
							axi_data_t'(run_count));
					end else if (stim_q[i].idx == `REG_MEM0_ADDR) begin
						cnt0 = data[`MEM0_ADDR_W-1:0];
					end else if (stim_q[i].idx == `REG_MEM1_ADDR) begin
						cnt1 = data[`MEM1_ADDR_W-1:0];
					end else if (stim_q[i].idx == `REG_MEM0_DATA) begin
						shadow0[cnt0] = data;
						check_data({name, " memory word"}, shadow0[cnt0], mem0[cnt0]);
						cnt0++;
					end
				end
				OP_READ: begin
					exp = stim_q[i].exp;
					if (stim_q[i].idx == `REG_MEM0_DATA) begin
						exp = shadow0[cnt0];
						cnt0++;
					end else if (stim_q[i].idx == `REG_MEM1_DATA) begin
						exp = shadow1[cnt1];
						cnt1++;
					end
					bus_read(stim_q[i].idx, data);
					check_data(name, exp, data);
				end
				default: begin
					pulse_inputs(stim_q[i].data);
				end
			endcase
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+verilog
+incdir+verification
verilog/accel_ctrl_pkg.sv
verilog/axi_lite_slave.sv
verilog/reg_decoder.sv
verilog/ctrl_status_regs.sv
verilog/mem_port_channel.sv
verilog/accel_ctrl_top.sv
verification/accel_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the accel_ctrl testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f \
	--top-module accel_ctrl_tb \
	-o Vaccel_ctrl_tb

./obj_dir/Vaccel_ctrl_tb
